// File: src/hp_pkg.sv
/* shared types and constants for the huge page transmit path
   one beat is one full quadword, no remainder mask on the link */
`default_nettype none

package hp_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int qword_w        = 64;    // link beat and host address
    localparam int page_hdr_bytes = 128;   // dw0 of the page holds the qword count
    localparam int max_tlp_qwords = 31;
    localparam int qcount_w       = 5;     // per-tlp qword count
    localparam int page_qcount_w  = 32;    // per-page qword count
    localparam int tag_w          = 4;     // tag wraps at 16

    // tlp fields
    localparam logic [6:0] tlp_fmt_type_mwr64 = 7'b11_00000;   // mem write, 4dw header
    localparam logic [3:0] tlp_be_all         = 4'hF;

    typedef struct packed {
        logic [qword_w-1:0] data;
        logic               sof;
        logic               eof;
    } tx_beat_t;

    typedef struct packed {
        logic [qcount_w-1:0] qwords;       // zero = close only
        logic                close_after;
    } data_cmd_t;

    typedef struct packed {
        logic [qword_w-1:0] addr;
        logic               ready;
    } page_desc_t;

    // first beat of a 64-bit address memory write
    function automatic logic [qword_w-1:0] mwr64_hdr(input logic [9:0]  len_dw,
                                                     input logic [15:0] req_id,
                                                     input logic [7:0]  tag);
        return {1'b0, tlp_fmt_type_mwr64, 1'b0, 3'b000, 4'b0000, 1'b0, 1'b0,
                2'b00, 2'b00, len_dw, req_id, tag, tlp_be_all, tlp_be_all};
    endfunction

    // host expects little endian qwords
    function automatic logic [qword_w-1:0] byte_rev64(input logic [qword_w-1:0] d);
        logic [qword_w-1:0] r;
        for (int i = 0; i < qword_w / 8; i++) begin
            r[8*i +: 8] = d[qword_w-8-8*i +: 8];
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: src/huge_page_slots.sv
/* two host pages used in turn, starting with page 1
   a slot is only taken once its ready input is seen high */
`default_nettype none

module huge_page_slots import hp_pkg::*; (
    input  logic               trn_clk,
    input  logic               reset_n,
    input  page_desc_t         page_1,
    input  page_desc_t         page_2,
    input  logic               page_done,       // one cycle pulse from close engine
    output logic [qword_w-1:0] cur_page_addr,
    output logic               page_available,
    output logic               page_free_1,
    output logic               page_free_2
);

    logic       slot;        // 0 = page 1, 1 = page 2
    page_desc_t cur_desc;

    assign cur_desc = slot ? page_2 : page_1;

    ////////////////////////////////////////////////////////////
    // slot pointer and availability
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            slot           <= 1'b0;
            page_available <= 1'b0;
            page_free_1    <= 1'b0;
            page_free_2    <= 1'b0;
        end else begin
            page_free_1 <= 1'b0;                          // pulses only
            page_free_2 <= 1'b0;
            if (page_done) begin
                page_free_1    <= ~slot;                  // hand current page back
                page_free_2    <= slot;
                page_available <= 1'b0;
                slot           <= ~slot;                  // other page next
            end else if (!page_available && cur_desc.ready) begin
                page_available <= 1'b1;
            end
        end
    end

    // base address follows the slot as it is taken
    always_ff @(posedge trn_clk) begin
        if (!page_available && !page_done && cur_desc.ready) begin
            cur_page_addr <= cur_desc.addr;
        end
    end

    // a close can only follow writes into a page we own
    a_done_needs_page : assert property (@(posedge trn_clk) disable iff (!reset_n)
        page_done |-> page_available);

endmodule

`default_nettype wire

// File: src/data_tlp_engine.sv
/* payload writes go to page base + 128 onward, 8 bytes per qword
   a zero qword command skips the write and only requests the close */
`default_nettype none

module data_tlp_engine import hp_pkg::*; (
    input  logic                     trn_clk,
    input  logic                     reset_n,
    input  data_cmd_t                cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic [qword_w-1:0]       pl_data,
    input  logic                     pl_valid,
    output logic                     pl_ready,
    input  logic [15:0]              completer_id,
    input  logic [qword_w-1:0]       cur_page_addr,
    input  logic                     page_available,
    input  logic                     page_done,
    output tx_beat_t                 beat,
    output logic                     beat_valid,
    input  logic                     beat_ready,
    output logic                     close_valid,
    input  logic                     close_ready,
    output logic [page_qcount_w-1:0] page_qwords
);

    typedef enum logic [2:0] {s_idle, s_hdr, s_addr, s_payload, s_close} state_t;

    state_t              state;
    logic [qcount_w-1:0] qwords_reg;      // qwords of the tlp in flight
    logic                close_after_reg;
    logic [qcount_w-1:0] qw_cnt;          // payload beats sent
    logic [tag_w-1:0]    tag_cnt;
    logic [qword_w-1:0]  wr_offset;       // byte offset inside the page
    logic                handed_off;      // close request taken
    logic                last_qw;
    logic                tx_fire;

    assign cmd_ready   = (state == s_idle) && page_available;
    assign pl_ready    = (state == s_payload) && beat_ready;
    assign close_valid = (state == s_close) && !handed_off;
    assign last_qw     = (qw_cnt == qwords_reg - 1'b1);
    assign tx_fire     = beat_valid && beat_ready;

    ////////////////////////////////////////////////////////////
    // beat mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        beat       = '0;
        beat_valid = 1'b0;
        case (state)
            s_hdr: begin
                beat.data  = mwr64_hdr({4'b0000, qwords_reg, 1'b0},    // dw = 2 x qw
                                       completer_id,
                                       {{(8 - tag_w){1'b0}}, tag_cnt});
                beat.sof   = 1'b1;
                beat_valid = 1'b1;
            end
            s_addr: begin
                beat.data  = cur_page_addr + wr_offset;
                beat_valid = 1'b1;
            end
            s_payload: begin
                beat.data  = byte_rev64(pl_data);
                beat.eof   = last_qw;
                beat_valid = pl_valid;                     // stream gates the link
            end
            default: begin
                beat_valid = 1'b0;
            end
        endcase
    end

    // command fields held for the whole tlp
    always_ff @(posedge trn_clk) begin
        if (cmd_valid && cmd_ready) begin
            qwords_reg      <= cmd.qwords;
            close_after_reg <= cmd.close_after;
        end
    end

    ////////////////////////////////////////////////////////////
    // FSM and page counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= s_idle;
            qw_cnt      <= '0;
            tag_cnt     <= '0;
            wr_offset   <= qword_w'(page_hdr_bytes);
            page_qwords <= '0;
            handed_off  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (cmd_valid && cmd_ready) begin
                        state <= (cmd.qwords == '0) ? s_close : s_hdr;
                    end
                end
                s_hdr: begin
                    if (tx_fire) state <= s_addr;
                end
                s_addr: begin
                    if (tx_fire) begin
                        qw_cnt <= '0;
                        state  <= s_payload;
                    end
                end
                s_payload: begin
                    if (tx_fire) begin
                        qw_cnt <= qw_cnt + 1'b1;
                        if (last_qw) begin
                            wr_offset   <= wr_offset + qword_w'({qwords_reg, 3'b000});
                            page_qwords <= page_qwords + page_qcount_w'(qwords_reg);
                            tag_cnt     <= tag_cnt + 1'b1;               // wraps at 16
                            state       <= close_after_reg ? s_close : s_idle;
                        end
                    end
                end
                s_close: begin
                    if (close_valid && close_ready) handed_off <= 1'b1;
                end
                default: state <= s_idle;
            endcase

            // new page starts from scratch
            if (page_done) begin
                wr_offset   <= qword_w'(page_hdr_bytes);
                tag_cnt     <= '0;
                page_qwords <= '0;
                handed_off  <= 1'b0;
                if (state == s_close) state <= s_idle;
            end
        end
    end

    a_qwords_max : assert property (@(posedge trn_clk) disable iff (!reset_n)
        (cmd_valid && cmd_ready) |-> (cmd.qwords <= max_tlp_qwords));

endmodule

`default_nettype wire

// File: src/close_tlp_engine.sv
/* writes the page qword count to the page base, tag fixed at 0
   page_done is combinational with the last beat handshake */
`default_nettype none

module close_tlp_engine import hp_pkg::*; (
    input  logic                     trn_clk,
    input  logic                     reset_n,
    input  logic                     close_valid,
    output logic                     close_ready,
    input  logic [page_qcount_w-1:0] page_qwords,
    input  logic [qword_w-1:0]       cur_page_addr,
    input  logic [15:0]              completer_id,
    input  logic                     interrupts_enabled,
    output tx_beat_t                 beat,
    output logic                     beat_valid,
    input  logic                     beat_ready,
    output logic                     page_done,
    output logic                     irq_req,
    input  logic                     irq_ack
);

    typedef enum logic [2:0] {c_idle, c_hdr, c_addr, c_count, c_irq} state_t;

    state_t                   state;
    logic [page_qcount_w-1:0] count_q;    // count captured at the request

    assign close_ready = (state == c_idle);
    assign page_done   = (state == c_count) && beat_ready;
    assign irq_req     = (state == c_irq);

    ////////////////////////////////////////////////////////////
    // beat mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        beat       = '0;
        beat_valid = 1'b1;
        case (state)
            c_hdr: begin
                beat.data = mwr64_hdr(10'd2, completer_id, 8'h00);   // 2 dw, tag 0
                beat.sof  = 1'b1;
            end
            c_addr: beat.data = cur_page_addr;                        // dw0 of the page
            c_count: begin
                beat.data = byte_rev64({32'h0000_0000, count_q});    // count in upper dw
                beat.eof  = 1'b1;
            end
            default: beat_valid = 1'b0;
        endcase
    end

    always_ff @(posedge trn_clk) begin
        if (close_valid && close_ready) count_q <= page_qwords;
    end

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= c_idle;
        end else begin
            case (state)
                c_idle: if (close_valid) state <= c_hdr;
                c_hdr: if (beat_ready) state <= c_addr;
                c_addr: if (beat_ready) state <= c_count;
                c_count: begin
                    if (beat_ready) state <= interrupts_enabled ? c_irq : c_idle;
                end
                c_irq: if (irq_ack) state <= c_idle;   // held until acked
                default: state <= c_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/tx_arbiter.sv
/* close builder wins when both start in the same cycle
   owner is kept from the accepted sof beat to the accepted eof beat */
`default_nettype none

module tx_arbiter import hp_pkg::*; (
    input  logic     trn_clk,
    input  logic     reset_n,
    input  tx_beat_t data_beat,
    input  tx_beat_t close_beat,
    input  logic     data_valid,
    input  logic     close_valid_beat,
    output logic     data_ready,
    output logic     close_ready_beat,
    output tx_beat_t tx_beat,
    output logic     tx_valid,
    input  logic     tx_ready
);

    typedef enum logic [1:0] {own_none, own_data, own_close} owner_t;

    owner_t owner;
    logic   sel_close;
    logic   sel_data;
    logic   tx_fire;

    // free link goes to whoever asks, close first
    assign sel_close = (owner == own_close) || (owner == own_none && close_valid_beat);
    assign sel_data  = (owner == own_data) ||
                       (owner == own_none && !close_valid_beat && data_valid);

    assign tx_beat          = sel_close ? close_beat : data_beat;
    assign tx_valid         = sel_close ? close_valid_beat : (sel_data && data_valid);
    assign data_ready       = sel_data && tx_ready;
    assign close_ready_beat = sel_close && tx_ready;
    assign tx_fire          = tx_valid && tx_ready;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            owner <= own_none;
        end else if (tx_fire) begin
            if (tx_beat.eof) begin
                owner <= own_none;                                  // tlp done
            end else if (tx_beat.sof) begin
                owner <= sel_close ? own_close : own_data;          // lock for the tlp
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // link rules
    ////////////////////////////////////////////////////////////
    a_hold_beat : assert property (@(posedge trn_clk) disable iff (!reset_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_beat)));

    a_sof_after_eof : assert property (@(posedge trn_clk) disable iff (!reset_n)
        (tx_fire && owner == own_none) |-> tx_beat.sof);

endmodule

`default_nettype wire

// File: src/hp_tx_top.sv
/* single clock domain, no credit check on the link
   host must not drop a page's ready while that page is in use */
`default_nettype none

module hp_tx_top import hp_pkg::*; (
    input  logic               trn_clk,
    input  logic               reset_n,
    input  data_cmd_t          cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  logic [qword_w-1:0] pl_data,
    input  logic               pl_valid,
    output logic               pl_ready,
    input  logic [15:0]        completer_id,
    input  page_desc_t         page_1,
    input  page_desc_t         page_2,
    output logic               page_free_1,
    output logic               page_free_2,
    input  logic               interrupts_enabled,
    output logic               irq_req,
    input  logic               irq_ack,
    output tx_beat_t           tx_beat,
    output logic               tx_valid,
    input  logic               tx_ready
);

    logic [qword_w-1:0]       cur_page_addr;
    logic                     page_available;
    logic                     page_done;
    logic                     close_valid;
    logic                     close_ready;
    logic [page_qcount_w-1:0] page_qwords;
    tx_beat_t                 data_beat;
    logic                     data_beat_valid;
    logic                     data_beat_ready;
    tx_beat_t                 close_beat;
    logic                     close_beat_valid;
    logic                     close_beat_ready;

    huge_page_slots u_slots (
        .trn_clk, .reset_n, .page_1, .page_2, .page_done,
        .cur_page_addr, .page_available, .page_free_1, .page_free_2
    );

    data_tlp_engine u_data (
        .trn_clk, .reset_n, .cmd, .cmd_valid, .cmd_ready,
        .pl_data, .pl_valid, .pl_ready, .completer_id,
        .cur_page_addr, .page_available, .page_done,
        .beat(data_beat), .beat_valid(data_beat_valid), .beat_ready(data_beat_ready),
        .close_valid, .close_ready, .page_qwords
    );

    close_tlp_engine u_close (
        .trn_clk, .reset_n, .close_valid, .close_ready, .page_qwords,
        .cur_page_addr, .completer_id, .interrupts_enabled,
        .beat(close_beat), .beat_valid(close_beat_valid), .beat_ready(close_beat_ready),
        .page_done, .irq_req, .irq_ack
    );

    tx_arbiter u_arb (
        .trn_clk, .reset_n,
        .data_beat, .close_beat,
        .data_valid(data_beat_valid), .close_valid_beat(close_beat_valid),
        .data_ready(data_beat_ready), .close_ready_beat(close_beat_ready),
        .tx_beat, .tx_valid, .tx_ready
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
/* free running clock of period 20 and an active low reset
   reset is held low for the first 3 cycles and released on a falling edge */
`default_nettype none

module tb_clock (
    output logic trn_clk,
    output logic reset_n
);

    initial begin
        trn_clk = 1'b0;
        forever #10 trn_clk = ~trn_clk;    // half of the 20 unit period
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge trn_clk);
        @(negedge trn_clk);
        reset_n = 1'b1;                    // released away from the rising edge
    end

endmodule

`default_nettype wire

// File: tests/tb_hp_tx.sv
/* table driven testbench with inputs changed on the falling edge and beats checked on the rising
   the model predicts every link beat, page_free pulse and irq_req from the page rules */
`default_nettype none

module tb_hp_tx import hp_pkg::*; ();

    typedef struct packed {
        int qw;             // 0 = close only
        bit close_after;
        bit irq_en;
        int pct;            // tx_ready probability in percent
        int reps;           // close_after only on the last repetition
    } row_t;

    typedef enum {w_reset, w_cmd_ready, w_drain, w_free, w_irq} wait_t;

    logic               trn_clk;
    logic               reset_n;
    data_cmd_t          cmd;
    logic               cmd_valid;
    logic               cmd_ready;
    logic [qword_w-1:0] pl_data;
    logic               pl_valid;
    logic               pl_ready;
    logic [15:0]        completer_id;
    page_desc_t         page_1;
    page_desc_t         page_2;
    logic               page_free_1;
    logic               page_free_2;
    logic               interrupts_enabled;
    logic               irq_req;
    logic               irq_ack;
    tx_beat_t           tx_beat;
    logic               tx_valid;
    logic               tx_ready;

    // reference model state
    tx_beat_t           exp_beats[$];
    logic [qword_w-1:0] page_base [2];
    logic [qword_w-1:0] exp_offset;
    int                 exp_tag;
    int                 exp_page_qw;
    int                 exp_slot;
    int unsigned        exp_pl_index;
    int                 free_due [2];
    int                 free_seen [2];
    bit                 irq_due;
    bit                 pl_taken;
    int unsigned        pl_index;
    int                 ready_pct;

    tb_clock u_clock (.trn_clk, .reset_n);

    hp_tx_top u_dut (.*);

    ////////////////////////////////////////////////////////////
    // checks and expected values
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input logic [qword_w+1:0] got,
                               input logic [qword_w+1:0] want);
        assert (got === want)
            else stop_on_error($sformatf("error: %s is %h, expected %h", name, got, want));
    endtask

    function automatic logic [qword_w-1:0] payload_word(input int unsigned i);
        return {32'h8100_0000 + i, 32'h7e00_0000 - i};    // one half counts up and one down
    endfunction

    // first byte on the wire lands at the lowest host address
    function automatic logic [qword_w-1:0] swap_bytes64(input logic [qword_w-1:0] d);
        logic [qword_w-1:0] r;
        for (int i = 0; i < 8; i++) begin
            r[63-8*i -: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    // mwr 4dw header as dw0 then dw1
    function automatic logic [qword_w-1:0] header_word(input int len_dw, input int tag);
        logic [31:0] dw0;
        logic [31:0] dw1;
        dw0 = {1'b0, tlp_fmt_type_mwr64, 14'd0, 10'(len_dw)};    // tc attr td and ep all zero
        dw1 = {completer_id, 8'(tag), 4'hf, 4'hf};              // all byte enables
        return {dw0, dw1};
    endfunction

    task automatic predict(input int qw, input bit closing);
        tx_beat_t b;
        logic [31:0] cnt;
        if (qw != 0) begin
            b = '{data: header_word(2 * qw, exp_tag), sof: 1'b1, eof: 1'b0};
            exp_beats.push_back(b);
            b = '{data: page_base[exp_slot] + exp_offset, sof: 1'b0, eof: 1'b0};
            exp_beats.push_back(b);
            for (int i = 0; i < qw; i++) begin
                b = '{data: swap_bytes64(payload_word(exp_pl_index)), sof: 1'b0,
                      eof: (i == qw - 1)};
                exp_beats.push_back(b);
                exp_pl_index++;
            end
            exp_offset  = exp_offset + 8 * qw;     // 8 bytes per qword
            exp_page_qw = exp_page_qw + qw;
            exp_tag     = (exp_tag + 1) % 16;
        end
        if (closing) begin
            cnt = exp_page_qw;
            b = '{data: header_word(2, 0), sof: 1'b1, eof: 1'b0};
            exp_beats.push_back(b);
            b = '{data: page_base[exp_slot], sof: 1'b0, eof: 1'b0};
            exp_beats.push_back(b);
            b = '{data: {cnt[7:0], cnt[15:8], cnt[23:16], cnt[31:24], 32'h0},
                  sof: 1'b0, eof: 1'b1};                       // count in upper dword
            exp_beats.push_back(b);
            free_due[exp_slot]++;
            exp_slot    = 1 - exp_slot;            // other page next
            exp_offset  = page_hdr_bytes;
            exp_page_qw = 0;
            exp_tag     = 0;
            irq_due     = interrupts_enabled;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // waits and handshakes
    ////////////////////////////////////////////////////////////
    function automatic bit condition_met(input wait_t what);
        case (what)
            w_reset:     return reset_n;
            w_cmd_ready: return cmd_ready;
            w_drain:     return exp_beats.size() == 0;
            w_free:      return free_seen[0] == free_due[0] && free_seen[1] == free_due[1];
            default:     return irq_req;
        endcase
    endfunction

    task automatic wait_for(input wait_t what, input string name);
        int cycles;
        cycles = 0;
        while (!condition_met(what)) begin
            @(negedge trn_clk);
            cycles++;
            assert (cycles < 5000) else stop_on_error($sformatf("timeout waiting for %s", name));
        end
    endtask

    task automatic send_command(input int qw, input bit closing);
        wait_for(w_cmd_ready, "cmd_ready");
        cmd.qwords      = 5'(qw);
        cmd.close_after = closing;
        cmd_valid       = 1'b1;                    // taken on the next rising edge
        predict(qw, closing);
        @(negedge trn_clk);
        cmd_valid = 1'b0;
        cmd       = '0;
        check_value("cmd_ready", cmd_ready, 0);    // engine left idle
    endtask

    task automatic ack_interrupt();
        wait_for(w_irq, "irq_req");
        repeat (3) begin
            @(negedge trn_clk);
            check_value("irq_req", irq_req, 1);    // held until acked
        end
        irq_ack = 1'b1;
        @(negedge trn_clk);
        irq_ack = 1'b0;
        irq_due = 1'b0;
        check_value("irq_req", irq_req, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // link side, sampled on the rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge trn_clk) begin : monitor
        tx_beat_t want;
        if (reset_n) begin
            pl_taken = pl_valid && pl_ready;
            if (tx_valid && tx_ready) begin
                assert (exp_beats.size() != 0)
                    else stop_on_error("a beat left the link while none was expected");
                want = exp_beats.pop_front();
                check_value("tx_beat", tx_beat, want);    // data, sof, eof
            end
            if (page_free_1) begin
                free_seen[0]++;
                assert (free_seen[0] <= free_due[0])
                    else stop_on_error("page_free_1 pulsed without a close of page 1");
            end
            if (page_free_2) begin
                free_seen[1]++;
                assert (free_seen[1] <= free_due[1])
                    else stop_on_error("page_free_2 pulsed without a close of page 2");
            end
            assert (!irq_req || (irq_due && exp_beats.size() == 0))
                else stop_on_error("irq_req rose without a finished close with interrupts on");
        end
    end

    // random back-pressure and payload stream
    initial begin : drive_link
        void'($urandom(32'h5739cd9b));
        tx_ready = 1'b0;
        pl_valid = 1'b0;
        pl_data  = '0;
        pl_index = 0;
        pl_taken = 1'b0;
        forever begin
            @(negedge trn_clk);
            if (reset_n) begin
                if (pl_taken) pl_index++;
                if (!pl_valid || pl_taken) begin           // valid held until taken
                    pl_valid = ($urandom % 4) != 0;
                    pl_data  = payload_word(pl_index);
                end
                tx_ready = ($urandom % 100) < ready_pct;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    initial begin : run
        row_t rows [9];
        bit   closing;
        cmd                = '0;
        cmd_valid          = 1'b0;
        completer_id       = 16'h0a01;
        interrupts_enabled = 1'b0;
        irq_ack            = 1'b0;
        irq_due            = 1'b0;
        ready_pct          = 100;
        page_base[0]       = 64'h0000_0001_0020_0000;    // 2 MB aligned
        page_base[1]       = 64'h0000_0002_0040_0000;
        page_1             = '{addr: page_base[0], ready: 1'b0};
        page_2             = '{addr: page_base[1], ready: 1'b0};
        exp_offset         = page_hdr_bytes;
        exp_tag            = 0;
        exp_page_qw        = 0;
        exp_slot           = 0;
        exp_pl_index       = 0;
        free_due           = '{0, 0};
        free_seen          = '{0, 0};
        rows = '{'{ 1, 0, 0, 100,  1},     // single qword
                 '{ 4, 0, 0, 100,  1},
                 '{31, 1, 1,  70,  1},     // largest tlp then close page 1 with irq
                 '{ 3, 0, 0,  50,  2},
                 '{ 7, 1, 0,  60,  1},     // close page 2 with irq off
                 '{ 2, 1, 0,  40, 18},     // tag wraps past 15
                 '{ 5, 0, 1,  80,  2},
                 '{ 0, 1, 1,  90,  1},     // close only
                 '{ 6, 1, 1,  30,  3}};

        wait_for(w_reset, "reset release");
        @(negedge trn_clk);
        check_value("tx_valid", tx_valid, 0);
        check_value("cmd_ready", cmd_ready, 0);
        check_value("pl_ready", pl_ready, 0);
        check_value("irq_req", irq_req, 0);
        check_value("page_free_1", page_free_1, 0);
        check_value("page_free_2", page_free_2, 0);
        page_1.ready = 1'b1;
        page_2.ready = 1'b1;

        foreach (rows[r]) begin
            interrupts_enabled = rows[r].irq_en;
            ready_pct          = rows[r].pct;
            for (int k = 0; k < rows[r].reps; k++) begin
                closing = (rows[r].qw == 0) || (rows[r].close_after && k == rows[r].reps - 1);
                send_command(rows[r].qw, closing);
                wait_for(w_drain, "the expected beats");
                if (closing) begin
                    wait_for(w_free, "page_free");
                    if (rows[r].irq_en) ack_interrupt();
                    else repeat (4) @(negedge trn_clk);    // irq must stay low
                end
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/hp_pkg.sv
src/huge_page_slots.sv
src/data_tlp_engine.sv
src/close_tlp_engine.sv
src/tx_arbiter.sv
src/hp_tx_top.sv
tests/tb_clock.sv
tests/tb_hp_tx.sv
